/* ctrl_pkg.sv */
////////////////////
// controller package: shared types and widths of the main controller
////////////////////
package ctrl_pkg;

  // register address width of the regfile
  localparam int REG_ADDR_W = 5;

  ////////////////////
  // controller states
  ////////////////////
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // pc source select towards the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // kind of control transfer seen by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand source select in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

endpackage

/* regfile_wr_if.sv */
////////////////////
// regfile write status from EX, ALU and WB for hazard and forwarding
////////////////////
`timescale 1ns/1ps

interface regfile_wr_if;

  // write enables of the later stages
  logic we_ex;
  logic we_wb;
  logic alu_we;

  // destination matches against the ID source registers
  logic wb_is_a;
  logic wb_is_b;
  logic alu_is_a;
  logic alu_is_b;

  // stall detection looks at everything
  modport hazard (
    input we_ex, we_wb, alu_we, wb_is_a, wb_is_b, alu_is_a, alu_is_b
  );

  // forwarding only needs the forwardable writers
  modport fwd (
    input we_wb, alu_we, wb_is_a, wb_is_b, alu_is_a, alu_is_b
  );

endinterface

/* ctrl_fsm.sv */
////////////////////
// controller fsm: boot, decode, flush, sleep, jumps and exceptions
////////////////////
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 exc_req_i,
  input  logic                 ext_req_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 jr_stall_i,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_save_takenbranch_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  // jump already issued for the instruction still sitting in ID
  logic        jump_done_q, jump_done;

  ////////////////////
  // next state and outputs
  ////////////////////
  always_comb
  begin
    // defaults: busy and fetching, no pc change
    state_d                = state_q;
    jump_done              = jump_done_q;
    ctrl_busy_o            = 1'b1;
    instr_req_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    unique case (state_q)
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into the fetch stage
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on enable or on a pending interrupt
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      FIRST_FETCH:
      begin
        // wait for the first instruction to reach ID
        if (id_ready_i)
          state_d = DECODE;
        if (exc_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          // unconditional jumps resolve straight from ID
          if (jump_in_dec_i == BRANCH_JAL || jump_in_dec_i == BRANCH_JALR)
          begin
            pc_mux_o = PC_JUMP;
            // jalr waits for its base register, and a jump fires only once
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            // keep the faulting instruction out of EX
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // exception return wins over the cases above
          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // wfi, or eret back to sleep, drains the pipeline
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // ID empty: external interrupt can be taken right away
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        // taken branch in EX kills the instruction in ID
        if (branch_taken_ex_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
          if (ext_req_i)
          begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      // let EX finish with nothing new entering
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      FLUSH_WB:
      begin
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          state_d = DECODE;
        end
        else
        begin
          halt_if_o = 1'b1;
          state_d   = SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////
  // state registers
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // flag only survives while ID holds the same instruction
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

  // no branch prediction, so taken branches never come back to back
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branches back to back");

  // a jump held in ID by a stall redirects fetch only once
  assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_o && pc_mux_o == PC_JUMP && !id_ready_i)
      |=> !(pc_set_o && pc_mux_o == PC_JUMP))
    else $error("jump redirected fetch twice");

endmodule

/* hazard_unit.sv */
////////////////////
// hazard unit: load-use and jalr stalls, write enable kill
////////////////////
`timescale 1ns/1ps

module hazard_unit (
  input  logic                 is_decoding_i,
  input  logic                 illegal_insn_i,
  input  logic                 data_req_ex_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  regfile_wr_if.hazard         wr,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);

  import ctrl_pkg::*;

  // jalr base register still in flight
  logic rs_a_pending;

  // load in EX writes a register that ID wants to read
  assign load_stall_o = data_req_ex_i & wr.we_ex & (wr.alu_is_a | wr.alu_is_b);

  // any stage about to write operand A, no forwarding into the pc
  assign rs_a_pending = (wr.we_wb  & wr.wb_is_a)  |
                        (wr.we_ex  & wr.alu_is_a) |
                        (wr.alu_we & wr.alu_is_a);

  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & rs_a_pending;

  // instruction must not commit: not decoding, illegal, or stalled
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

/* operand_fwd.sv */
////////////////////
// operand forwarding select for A and B
////////////////////
`timescale 1ns/1ps

module operand_fwd (
  regfile_wr_if.fwd          wr,
  output ctrl_pkg::fw_sel_e  operand_a_fw_mux_sel_o,
  output ctrl_pkg::fw_sel_e  operand_b_fw_mux_sel_o
);

  import ctrl_pkg::*;

  always_comb
  begin
    // default straight from the regfile
    operand_a_fw_mux_sel_o = SEL_REGFILE;
    operand_b_fw_mux_sel_o = SEL_REGFILE;

    // older result from WB
    if (wr.we_wb)
    begin
      if (wr.wb_is_a)
        operand_a_fw_mux_sel_o = SEL_FW_WB;
      if (wr.wb_is_b)
        operand_b_fw_mux_sel_o = SEL_FW_WB;
    end

    // younger ALU result from EX overrides WB
    if (wr.alu_we)
    begin
      if (wr.alu_is_a)
        operand_a_fw_mux_sel_o = SEL_FW_EX;
      if (wr.alu_is_b)
        operand_b_fw_mux_sel_o = SEL_FW_EX;
    end
  end

endmodule

/* riscv_ctrl_top.sv */
////////////////////
// main controller top: fsm, hazard unit and forwarding unit
////////////////////
`timescale 1ns/1ps

module riscv_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 illegal_insn_i,
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e jump_in_id_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                 exc_req_i,
  input  logic                 ext_req_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 data_req_ex_i,
  input  logic                 regfile_we_ex_i,
  input  logic                 regfile_we_wb_i,
  input  logic                 regfile_alu_we_fw_i,
  input  logic                 reg_d_wb_is_reg_a_i,
  input  logic                 reg_d_wb_is_reg_b_i,
  input  logic                 reg_d_alu_is_reg_a_i,
  input  logic                 reg_d_alu_is_reg_b_i,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_save_takenbranch_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 deassert_we_o,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output ctrl_pkg::fw_sel_e    operand_a_fw_mux_sel_o,
  output ctrl_pkg::fw_sel_e    operand_b_fw_mux_sel_o
);

  // jump_in_id_i is the ID-stage copy of the jump kind, decisions use the decoder's
  regfile_wr_if wr_if ();

  // write status bundle for hazard and forwarding
  assign wr_if.we_ex    = regfile_we_ex_i;
  assign wr_if.we_wb    = regfile_we_wb_i;
  assign wr_if.alu_we   = regfile_alu_we_fw_i;
  assign wr_if.wb_is_a  = reg_d_wb_is_reg_a_i;
  assign wr_if.wb_is_b  = reg_d_wb_is_reg_b_i;
  assign wr_if.alu_is_a = reg_d_alu_is_reg_a_i;
  assign wr_if.alu_is_b = reg_d_alu_is_reg_b_i;

  ////////////////////
  // sequencing
  ////////////////////
  ctrl_fsm u_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  // stalls, fed by the decode flag of the fsm
  hazard_unit u_hazard (
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .data_req_ex_i  (data_req_ex_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .wr             (wr_if.hazard),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  // operand muxes in ID
  operand_fwd u_fwd (
    .wr                     (wr_if.fwd),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o)
  );

endmodule

/* tb_clkgen.sv */
////////////////////
// testbench clock and reset generator
////////////////////
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int CLK_PERIOD   = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // release away from the rising edge so the async reset never races it
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tb_ctrl.sv */
////////////////////
// controller testbench: random stimulus checked against a cycle model
////////////////////
`timescale 1ns/1ps

module tb_ctrl;

  import ctrl_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CYCLES   = 3000;
  // cycle budget before the watchdog fires
  localparam int WDOG_CYCLES  = 4000;

  logic clk, rst_n;
  logic fetch_enable_i, illegal_insn_i, eret_insn_i, pipe_flush_i;
  logic instr_valid_i, branch_taken_ex_i, exc_req_i, ext_req_i;
  logic id_ready_i, ex_valid_i, data_req_ex_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i;
  logic reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i;
  jump_kind_e jump_in_id_i, jump_in_dec_i;
  logic ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o;
  logic exc_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o;
  logic exc_restore_id_o, halt_if_o, halt_id_o;
  logic deassert_we_o, load_stall_o, jr_stall_o;
  pc_mux_e pc_mux_o;
  fw_sel_e operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o;

  // model state and expected outputs
  ctrl_state_e m_state, e_next;
  logic        m_jd, e_jd;
  logic        e_busy, e_req, e_dec, e_pcset, e_ack, e_sif, e_sid, e_stb, e_rst;
  logic        e_hif, e_hid, e_load, e_jr, e_dwe;
  pc_mux_e     e_mux;
  fw_sel_e     e_fa, e_fb;
  logic [31:0] rng;
  string       tname;

  tb_clkgen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  riscv_ctrl_top dut0 (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("** Error [%s] expected %0h actual %0h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  task automatic drive_inputs();
    logic [31:0] r1, r2;
    rng = xorshift(rng);
    r1  = rng;
    rng = xorshift(rng);
    r2  = rng;
    // mostly enabled, dropped now and then so flushes can end in sleep
    fetch_enable_i       = (r1[1:0] != 2'b00);
    instr_valid_i        = (r1[3:2] != 2'b00);
    // never two taken branches in a row
    branch_taken_ex_i    = (r1[6:4] == 3'd0) && !branch_taken_ex_i;
    jump_in_dec_i        = jump_kind_e'(r1[8:7]);
    jump_in_id_i         = jump_kind_e'(r1[10:9]);
    eret_insn_i          = (r1[14:11] == 4'd0);
    pipe_flush_i         = (r1[18:15] == 4'd0);
    exc_req_i            = (r1[21:19] == 3'd0);
    ext_req_i            = (r1[24:22] == 3'd0);
    // id_ready low often enough to hold the jump-done flag
    id_ready_i           = (r1[26:25] != 2'b00);
    ex_valid_i           = (r1[28:27] != 2'b00);
    illegal_insn_i       = (r1[31:29] == 3'd0);
    data_req_ex_i        = r2[0];
    regfile_we_ex_i      = r2[1];
    regfile_we_wb_i      = r2[2];
    regfile_alu_we_fw_i  = r2[3];
    reg_d_wb_is_reg_a_i  = r2[4];
    reg_d_wb_is_reg_b_i  = r2[5];
    reg_d_alu_is_reg_a_i = r2[6];
    reg_d_alu_is_reg_b_i = r2[7];
  endtask

  ////////////////////
  // reference model
  ////////////////////
  task automatic predict();
    logic jump;
    {e_dec, e_pcset, e_ack, e_sif, e_sid, e_stb, e_rst, e_hif, e_hid} = '0;
    e_busy = 1'b1;
    e_req  = 1'b1;
    e_mux  = PC_BOOT;
    e_next = m_state;
    e_jd   = m_jd;
    jump   = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);
    // jalr stall from inputs alone, the fsm needs it in decode
    e_jr   = (jump_in_dec_i == BRANCH_JALR) &&
             ((regfile_we_wb_i && reg_d_wb_is_reg_a_i) ||
              ((regfile_we_ex_i || regfile_alu_we_fw_i) && reg_d_alu_is_reg_a_i));
    case (m_state)
      RESET:
      begin
        {e_busy, e_req} = 2'b00;
        e_next = fetch_enable_i ? BOOT_SET : RESET;
      end
      BOOT_SET:
      begin
        e_pcset = 1'b1;
        e_next  = FIRST_FETCH;
      end
      SLEEP:
      begin
        {e_busy, e_req, e_hif, e_hid} = 4'b0011;
        if (fetch_enable_i || exc_req_i)
          e_next = FIRST_FETCH;
      end
      FIRST_FETCH:
      begin
        if (id_ready_i)
          e_next = DECODE;
        if (exc_req_i)
        begin
          {e_pcset, e_ack, e_sif} = 3'b111;
          e_mux = PC_EXCEPTION;
        end
      end
      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // redirect from EX, an interrupt rides along with it
          e_pcset = 1'b1;
          e_mux   = ext_req_i ? PC_EXCEPTION : PC_BRANCH;
          {e_ack, e_hid, e_stb} = {3{ext_req_i}};
        end
        else if (!instr_valid_i)
        begin
          {e_pcset, e_ack, e_hid, e_sif} = {4{ext_req_i}};
          if (ext_req_i)
            e_mux = PC_EXCEPTION;
        end
        else
        begin
          e_dec = 1'b1;
          // exception side effects only when no jump in ID
          {e_ack, e_hid, e_sid} = {3{exc_req_i && !jump}};
          if (eret_insn_i)
          begin
            e_mux   = PC_ERET;
            e_rst   = 1'b1;
            e_pcset = !m_jd || (exc_req_i && !jump);
            e_jd    = 1'b1;
          end
          else if (jump)
          begin
            e_mux   = PC_JUMP;
            e_pcset = !e_jr && !m_jd;
            e_jd    = m_jd || e_pcset;
          end
          else if (exc_req_i)
          begin
            e_mux   = PC_EXCEPTION;
            e_pcset = 1'b1;
          end
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            {e_hif, e_hid} = 2'b11;
            e_next = FLUSH_EX;
          end
        end
      end
      FLUSH_EX:
      begin
        {e_hif, e_hid} = 2'b11;
        if (ex_valid_i)
          e_next = FLUSH_WB;
      end
      FLUSH_WB:
      begin
        e_hid  = 1'b1;
        e_hif  = !fetch_enable_i;
        e_next = fetch_enable_i ? DECODE : SLEEP;
      end
      default:
      begin
        e_next = RESET;
      end
    endcase
    e_load = data_req_ex_i && regfile_we_ex_i && (reg_d_alu_is_reg_a_i || reg_d_alu_is_reg_b_i);
    e_dwe  = !e_dec || illegal_insn_i || e_load || e_jr;
    // EX result beats WB result beats regfile
    e_fa = (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i) ? SEL_FW_EX :
           (regfile_we_wb_i && reg_d_wb_is_reg_a_i) ? SEL_FW_WB : SEL_REGFILE;
    e_fb = (regfile_alu_we_fw_i && reg_d_alu_is_reg_b_i) ? SEL_FW_EX :
           (regfile_we_wb_i && reg_d_wb_is_reg_b_i) ? SEL_FW_WB : SEL_REGFILE;
  endtask

  task automatic compare();
    case (m_state)
      RESET, BOOT_SET:     tname = "boot";
      DECODE:              tname = "decode";
      FIRST_FETCH:         tname = "first_fetch";
      default:             tname = "flush_sleep";
    endcase
    check({tname, ".busy"}, 32'(e_busy), 32'(ctrl_busy_o));
    check({tname, ".instr_req"}, 32'(e_req), 32'(instr_req_o));
    check({tname, ".is_decoding"}, 32'(e_dec), 32'(is_decoding_o));
    check({tname, ".pc_set"}, 32'(e_pcset), 32'(pc_set_o));
    check({tname, ".pc_mux"}, 32'(e_mux), 32'(pc_mux_o));
    check({tname, ".exc_ack"}, 32'(e_ack), 32'(exc_ack_o));
    check({tname, ".exc_save_if"}, 32'(e_sif), 32'(exc_save_if_o));
    check({tname, ".exc_save_id"}, 32'(e_sid), 32'(exc_save_id_o));
    check({tname, ".exc_save_tb"}, 32'(e_stb), 32'(exc_save_takenbranch_o));
    check({tname, ".exc_restore"}, 32'(e_rst), 32'(exc_restore_id_o));
    check({tname, ".halt_if"}, 32'(e_hif), 32'(halt_if_o));
    check({tname, ".halt_id"}, 32'(e_hid), 32'(halt_id_o));
    check("stalls.load", 32'(e_load), 32'(load_stall_o));
    check("stalls.jr", 32'(e_jr), 32'(jr_stall_o));
    check("stalls.deassert_we", 32'(e_dwe), 32'(deassert_we_o));
    check("forwarding.a", 32'(e_fa), 32'(operand_a_fw_mux_sel_o));
    check("forwarding.b", 32'(e_fb), 32'(operand_b_fw_mux_sel_o));
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial
  begin
    rng = 32'h38504fbd;
    {fetch_enable_i, illegal_insn_i, eret_insn_i, pipe_flush_i} = '0;
    {instr_valid_i, branch_taken_ex_i, exc_req_i, ext_req_i} = '0;
    {id_ready_i, ex_valid_i, data_req_ex_i} = '0;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = '0;
    {reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i} = '0;
    {reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i} = '0;
    jump_in_id_i  = BRANCH_NONE;
    jump_in_dec_i = BRANCH_NONE;
    m_state = RESET;
    m_jd    = 1'b0;
    for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++)
    begin
      @(posedge clk);
      // advance the model on the same edge as the DUT
      if (!rst_n)
      begin
        m_state = RESET;
        m_jd    = 1'b0;
      end
      else
      begin
        m_state = e_next;
        m_jd    = e_jd && !id_ready_i;
      end
      #1;
      drive_inputs();
      // outputs settled, well before the next edge
      #2;
      predict();
      compare();
    end
    $display("TB PASSED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WDOG_CYCLES * CLK_PERIOD + 100);
    $display("TB FAILED");
    $fatal(1, "watchdog expired, the run did not finish in time");
  end

endmodule

/* sim.f */
ctrl_pkg.sv
regfile_wr_if.sv
ctrl_fsm.sv
hazard_unit.sv
operand_fwd.sv
riscv_ctrl_top.sv
tb_clkgen.sv
tb_ctrl.sv

/* Makefile */
# Verilator build and run of the controller testbench

TOOL       := verilator
TOP        := tb_ctrl
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
